// ==== verilog/soc_pkg.sv ====
// ----------------------------------------
// bus widths and I/O selects shared by the fabric
// FIFO_DEPTH must stay a power of two
// ----------------------------------------
package soc_pkg;

	// byte-wide memory bus with a 32-bit address
	localparam int ADDR_W = 32;
	localparam int DATA_W = 8;
	localparam int IO_SEL_W = 3;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;

	// low address bits inside the I/O window
	typedef logic [IO_SEL_W-1:0] io_sel_t;

	// write pushes one character to the transmit queue
	localparam io_sel_t IO_SEL_CHAR = 3'd0;

	// read gives status, bit 0 fifo full, bit 1 transmitter busy
	localparam io_sel_t IO_SEL_STATUS = 3'd1;

	// write stores the exit code and stops the core
	localparam io_sel_t IO_SEL_FINISH = 3'd4;

	// transmit queue entries
	localparam int FIFO_DEPTH = 8;

endpackage

// ==== verilog/reset_sync.sv ====
// ----------------------------------------
// async assert, release two edges after btnC falls
// ----------------------------------------
`timescale 1ns/1ns

module reset_sync
(
	input  logic clk,
	input  logic btnC,
	input  logic finish,
	output logic rst,
	output logic cpu_rst
);

	logic rst_delay;

	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			rst_delay <= 1'b1;
			rst <= 1'b1;
		end
		else
		begin
			rst_delay <= 1'b0;
			rst <= rst_delay;
		end
	end

	// core stays held once the program has ended
	assign cpu_rst = rst | finish;

endmodule

// ==== verilog/bus_master_mux.sv ====
// ----------------------------------------
// host wins the bus while host_active is high
// host address is zero-extended, so it sees RAM only
// ----------------------------------------
`timescale 1ns/1ns

module bus_master_mux
#(
	parameter int ram_addr_width = 17
)
(
	input  soc_pkg::addr_t            cpu_a,
	input  soc_pkg::byte_t            cpu_dout,
	input  logic                      cpu_wr,
	input  logic                      host_active,
	input  logic [ram_addr_width-1:0] host_a,
	input  soc_pkg::byte_t            host_dout,
	input  logic                      host_wr,
	input  soc_pkg::byte_t            rd_data,
	output soc_pkg::addr_t            mc_a,
	output logic                      mc_wr,
	output soc_pkg::byte_t            mc_dout,
	output logic                      cpu_rdy,
	output soc_pkg::byte_t            cpu_din,
	output soc_pkg::byte_t            host_din,
	output logic                      led
);

	import soc_pkg::*;

	addr_t host_a_ext;

	// upper bits zero keep the host out of the I/O window
	assign host_a_ext = {{($bits(addr_t) - ram_addr_width){1'b0}}, host_a};

	assign mc_a = host_active ? host_a_ext : cpu_a;
	assign mc_wr = host_active ? host_wr : cpu_wr;
	assign mc_dout = host_active ? host_dout : cpu_dout;

	// debug break pauses the core and lights the led
	assign cpu_rdy = ~host_active;
	assign led = host_active;

	// both masters see the same returned byte
	assign cpu_din = rd_data;
	assign host_din = rd_data;

endmodule

// ==== verilog/mem_decode.sv ====
// ----------------------------------------
// top two window bits both set selects I/O
// read data belongs to the previous cycle's address
// ----------------------------------------
`timescale 1ns/1ns

module mem_decode
#(
	parameter int ram_addr_width = 17
)
(
	input  logic                      clk,
	input  logic                      rst,
	input  soc_pkg::addr_t            mc_a,
	input  logic                      mc_wr,
	input  soc_pkg::byte_t            mc_dout,
	input  soc_pkg::byte_t            ram_dout,
	input  soc_pkg::byte_t            io_dout,
	output logic                      ram_en,
	output logic [ram_addr_width-1:0] ram_a,
	output logic                      ram_wr,
	output soc_pkg::byte_t            ram_din,
	output logic                      io_en,
	output soc_pkg::io_sel_t          io_sel,
	output logic                      io_wr,
	output soc_pkg::byte_t            io_din,
	output soc_pkg::byte_t            rd_data
);

	logic io_window;
	logic io_en_q;

	// bits ram_addr_width and ram_addr_width-1
	assign io_window = (mc_a[ram_addr_width -: 2] == 2'b11);

	assign ram_en = ~io_window;
	assign ram_a = mc_a[ram_addr_width-1:0];
	assign ram_wr = mc_wr;
	assign ram_din = mc_dout;

	assign io_en = io_window;
	assign io_sel = mc_a[2:0];
	assign io_wr = mc_wr;
	assign io_din = mc_dout;

	// both targets answer one cycle late, so the select must follow
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			io_en_q <= 1'b0;
		else
			io_en_q <= io_en;
	end

	assign rd_data = io_en_q ? io_dout : ram_dout;

endmodule

// ==== verilog/ram.sv ====
// ----------------------------------------
// single port, read registered, no reset on contents
// ----------------------------------------
`timescale 1ns/1ns

module ram
#(
	parameter int ram_addr_width = 17
)
(
	input  logic                      clk,
	input  logic                      ram_en,
	input  logic                      ram_wr,
	input  logic [ram_addr_width-1:0] ram_a,
	input  soc_pkg::byte_t            ram_din,
	output soc_pkg::byte_t            ram_dout
);

	import soc_pkg::*;

	byte_t mem [2**ram_addr_width];

	// output holds its last value during a write
	always_ff @(posedge clk)
	begin
		if (ram_en)
		begin
			if (ram_wr)
				mem[ram_a] <= ram_din;
			else
				ram_dout <= mem[ram_a];
		end
	end

endmodule

// ==== verilog/io_ctrl.sv ====
// ----------------------------------------
// writes while the queue is full are dropped
// exit code is captured once per reset
// ----------------------------------------
`timescale 1ns/1ns

module io_ctrl
(
	input  logic             clk,
	input  logic             rst,
	input  logic             io_en,
	input  soc_pkg::io_sel_t io_sel,
	input  logic             io_wr,
	input  soc_pkg::byte_t   io_din,
	input  logic             tx_ready,
	output soc_pkg::byte_t   io_dout,
	output logic             io_full,
	output logic             tx_valid,
	output soc_pkg::byte_t   tx_byte,
	output logic             finish,
	output soc_pkg::byte_t   exit_code
);

	import soc_pkg::*;

	localparam int ptr_w = $clog2(FIFO_DEPTH);
	localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

	byte_t fifo [FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic char_wr;
	logic fin_wr;
	logic status_rd;
	logic push;
	logic pop;

	assign char_wr = io_en & io_wr & (io_sel == IO_SEL_CHAR);
	assign fin_wr = io_en & io_wr & (io_sel == IO_SEL_FINISH);
	assign status_rd = io_en & ~io_wr & (io_sel == IO_SEL_STATUS);

	assign push = char_wr & ~io_full;
	assign pop = tx_valid & tx_ready;

	assign io_full = (count == cnt_w'(FIFO_DEPTH));
	assign tx_valid = (count != '0);
	assign tx_byte = fifo[rd_ptr];

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			fifo[wr_ptr] <= io_din;
	end

	// unused selects read back as zero
	always_ff @(posedge clk)
	begin
		if (status_rd)
			io_dout <= {6'b0, ~tx_ready, io_full};
		else
			io_dout <= '0;
	end

	// program finish latch
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			finish <= 1'b0;
		else if (fin_wr)
			finish <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (fin_wr && !finish)
			exit_code <= io_din;
	end

endmodule

// ==== verilog/uart_tx.sv ====
// ----------------------------------------
// 8N1, lsb first, clks_per_bit cycles per bit
// ----------------------------------------
`timescale 1ns/1ns

module uart_tx
#(
	parameter int clks_per_bit = 8
)
(
	input  logic           clk,
	input  logic           rst,
	input  logic           tx_valid,
	input  soc_pkg::byte_t tx_byte,
	output logic           tx_ready,
	output logic           tx
);

	import soc_pkg::*;

	localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

	typedef enum logic [1:0] {idle, start, data, stop} tx_state_t;

	tx_state_t state;
	logic [cnt_w-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic baud_done;
	byte_t shift_reg;

	assign baud_done = (baud_cnt == cnt_w'(clks_per_bit - 1));
	assign tx_ready = (state == idle);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= idle;
			baud_cnt <= '0;
			bit_idx <= '0;
		end
		else if (state == idle)
		begin
			baud_cnt <= '0;
			bit_idx <= '0;
			if (tx_valid)
				state <= start;
		end
		else if (!baud_done)
			baud_cnt <= baud_cnt + 1'b1;
		else
		begin
			baud_cnt <= '0;
			case (state)
				start: state <= data;
				data:
				begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= stop;
				end
				default: state <= idle;
			endcase
		end
	end

	// byte is taken on the accept cycle
	always_ff @(posedge clk)
	begin
		if (tx_ready && tx_valid)
			shift_reg <= tx_byte;
	end

	always_comb
	begin
		case (state)
			start: tx = 1'b0;
			data: tx = shift_reg[bit_idx];
			default: tx = 1'b1;
		endcase
	end

endmodule

// ==== verilog/soc_top.sv ====
// ----------------------------------------
// core is external; clks_per_bit of 8 suits simulation only
// ----------------------------------------
`timescale 1ns/1ns

module soc_top
#(
	parameter int ram_addr_width = 17,
	parameter int clks_per_bit = 8
)
(
	input  logic                      clk,
	input  logic                      btnC,
	input  soc_pkg::addr_t            cpu_a,
	input  soc_pkg::byte_t            cpu_dout,
	input  logic                      cpu_wr,
	output soc_pkg::byte_t            cpu_din,
	output logic                      cpu_rdy,
	output logic                      cpu_rst,
	input  logic                      host_active,
	input  logic [ram_addr_width-1:0] host_a,
	input  soc_pkg::byte_t            host_dout,
	input  logic                      host_wr,
	output soc_pkg::byte_t            host_din,
	output logic                      tx,
	output logic                      led,
	output logic                      finish,
	output soc_pkg::byte_t            exit_code
);

	import soc_pkg::*;

	logic rst;

	// shared memory bus
	addr_t mc_a;
	logic mc_wr;
	byte_t mc_dout;
	byte_t rd_data;

	logic ram_en;
	logic [ram_addr_width-1:0] ram_a;
	logic ram_wr;
	byte_t ram_din;
	byte_t ram_dout;

	logic io_en;
	io_sel_t io_sel;
	logic io_wr;
	byte_t io_din;
	byte_t io_dout;
	logic io_full;

	// fifo to serializer handshake
	logic tx_valid;
	byte_t tx_byte;
	logic tx_ready;

	reset_sync u_reset_sync
	(
		.clk(clk),
		.btnC(btnC),
		.finish(finish),
		.rst(rst),
		.cpu_rst(cpu_rst)
	);

	bus_master_mux #(.ram_addr_width(ram_addr_width)) u_bus_master_mux
	(
		.cpu_a(cpu_a),
		.cpu_dout(cpu_dout),
		.cpu_wr(cpu_wr),
		.host_active(host_active),
		.host_a(host_a),
		.host_dout(host_dout),
		.host_wr(host_wr),
		.rd_data(rd_data),
		.mc_a(mc_a),
		.mc_wr(mc_wr),
		.mc_dout(mc_dout),
		.cpu_rdy(cpu_rdy),
		.cpu_din(cpu_din),
		.host_din(host_din),
		.led(led)
	);

	mem_decode #(.ram_addr_width(ram_addr_width)) u_mem_decode
	(
		.clk(clk),
		.rst(rst),
		.mc_a(mc_a),
		.mc_wr(mc_wr),
		.mc_dout(mc_dout),
		.ram_dout(ram_dout),
		.io_dout(io_dout),
		.ram_en(ram_en),
		.ram_a(ram_a),
		.ram_wr(ram_wr),
		.ram_din(ram_din),
		.io_en(io_en),
		.io_sel(io_sel),
		.io_wr(io_wr),
		.io_din(io_din),
		.rd_data(rd_data)
	);

	ram #(.ram_addr_width(ram_addr_width)) u_ram
	(
		.clk(clk),
		.ram_en(ram_en),
		.ram_wr(ram_wr),
		.ram_a(ram_a),
		.ram_din(ram_din),
		.ram_dout(ram_dout)
	);

	io_ctrl u_io_ctrl
	(
		.clk(clk),
		.rst(rst),
		.io_en(io_en),
		.io_sel(io_sel),
		.io_wr(io_wr),
		.io_din(io_din),
		.tx_ready(tx_ready),
		.io_dout(io_dout),
		.io_full(io_full),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.finish(finish),
		.exit_code(exit_code)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx
	(
		.clk(clk),
		.rst(rst),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.tx(tx)
	);

endmodule

// ==== tests/soc_properties.sv ====
// ----------------------------------------
// bound into soc_top, uses its internal names
// ----------------------------------------
`timescale 1ns/1ns

module soc_properties
(
	input logic clk,
	input logic btnC,
	input logic rst,
	input logic host_active,
	input logic led,
	input logic cpu_rdy,
	input logic tx,
	input logic tx_ready,
	input logic finish,
	input logic cpu_rst,
	input logic io_full
);

	int failures = 0;

	led_follows_host: assert property (@(posedge clk) led == host_active)
	else
	begin
		failures++;
		$error("led differs from host_active");
	end

	rdy_inverts_led: assert property (@(posedge clk) cpu_rdy == !led)
	else
	begin
		failures++;
		$error("cpu_rdy is not the inverse of led");
	end

	// line idles high between frames
	idle_line_high: assert property (@(posedge clk) disable iff (rst) tx_ready |-> tx)
	else
	begin
		failures++;
		$error("tx low while the transmitter is idle");
	end

	core_held_after_finish: assert property (@(posedge clk) disable iff (btnC)
		finish |=> cpu_rst)
	else
	begin
		failures++;
		$error("cpu_rst fell after finish");
	end

	// only a pop by the idle transmitter frees a slot
	full_falls_on_pop: assert property (@(posedge clk) disable iff (rst)
		$fell(io_full) |-> $past(tx_ready))
	else
	begin
		failures++;
		$error("io_full fell without a frame ending");
	end

endmodule

bind soc_top soc_properties u_props
(
	.clk(clk),
	.btnC(btnC),
	.rst(rst),
	.host_active(host_active),
	.led(led),
	.cpu_rdy(cpu_rdy),
	.tx(tx),
	.tx_ready(tx_ready),
	.finish(finish),
	.cpu_rst(cpu_rst),
	.io_full(io_full)
);

// ==== tests/soc_tb.sv ====
// ----------------------------------------
// plays the core and the host on the byte bus
// expects clks_per_bit of 8 and a 17-bit RAM address
// ----------------------------------------
`timescale 1ns/1ns

module soc_tb;

	import soc_pkg::*;

	localparam int ram_aw = 17;
	localparam int cpb = 8;
	localparam int frame_cycles = 10 * cpb;
	localparam int n_random = 48;

	// I/O window has bits ram_aw and ram_aw-1 both set
	localparam addr_t io_base = addr_t'(3) << (ram_aw - 1);
	// every RAM address lies below bit ram_aw
	localparam addr_t ram_mask = (addr_t'(1) << ram_aw) - 1;

	logic clk;
	logic btnC;
	addr_t cpu_a;
	byte_t cpu_dout;
	logic cpu_wr;
	byte_t cpu_din;
	logic cpu_rdy;
	logic cpu_rst;
	logic host_active;
	logic [ram_aw-1:0] host_a;
	byte_t host_dout;
	logic host_wr;
	byte_t host_din;
	logic tx;
	logic led;
	logic finish;
	byte_t exit_code;

	int seed = 91616;
	byte_t shadow [addr_t];
	addr_t written_q [$];
	byte_t exp_q [$];
	byte_t rx_q [$];

	soc_top #(.ram_addr_width(ram_aw), .clks_per_bit(cpb)) uut (.*);

	always #5 clk = ~clk;

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			stop_run();
		end
	endtask

	// write is sampled on the second edge, the idle cycle after drops the strobe
	task automatic core_write(input addr_t a, input byte_t d);
		@(posedge clk);
		cpu_a <= a;
		cpu_dout <= d;
		cpu_wr <= 1'b1;
		@(posedge clk);
		cpu_wr <= 1'b0;
	endtask

	task automatic core_read(input addr_t a, output byte_t d);
		@(posedge clk);
		cpu_a <= a;
		cpu_wr <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		d = cpu_din;
	endtask

	task automatic host_write(input addr_t a, input byte_t d);
		@(posedge clk);
		host_a <= a[ram_aw-1:0];
		host_dout <= d;
		host_wr <= 1'b1;
		@(posedge clk);
		host_wr <= 1'b0;
	endtask

	task automatic host_read(input addr_t a, output byte_t d);
		@(posedge clk);
		host_a <= a[ram_aw-1:0];
		host_wr <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		d = host_din;
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (cpu_rst !== 1'b0)
		begin
			if (cycles == 10)
			begin
				$display("reset did not release within 10 cycles after btnC fell");
				stop_run();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// polls status bit 1 until the transmitter is back in idle
	task automatic wait_tx_idle();
		byte_t status;
		int polls;
		polls = 0;
		core_read(io_base + IO_SEL_STATUS, status);
		while (status[1])
		begin
			if (polls == frame_cycles)
			begin
				$display("transmitter stayed busy while polling status");
				stop_run();
			end
			core_read(io_base + IO_SEL_STATUS, status);
			polls++;
		end
	endtask

	task automatic wait_frames(input int n);
		int cycles;
		cycles = 0;
		while (rx_q.size() < n)
		begin
			if (cycles > (n + 1) * frame_cycles + 50)
			begin
				$display("only %0d of %0d UART frames arrived", rx_q.size(), n);
				stop_run();
			end
			@(negedge clk);
			cycles++;
		end
		repeat (n)
			check_value("tx byte", exp_q.pop_front(), rx_q.pop_front());
	endtask

	// samples each bit near its middle and queues the byte
	initial
	begin
		byte_t rx_byte;
		@(negedge btnC);
		forever
		begin
			@(negedge tx);
			repeat (cpb / 2) @(negedge clk);
			check_value("tx start bit", 0, tx);
			for (int b = 0; b < 8; b++)
			begin
				repeat (cpb) @(negedge clk);
				rx_byte[b] = tx;
			end
			repeat (cpb) @(negedge clk);
			check_value("tx stop bit", 1, tx);
			rx_q.push_back(rx_byte);
		end
	end

	// concurrent assertion failures are counted in the bound checker
	always @(negedge clk)
	begin
		if (uut.u_props.failures != 0)
		begin
			$display("a bus or UART property failed, see the error above");
			stop_run();
		end
	end

	initial
	begin
		#((20 * frame_cycles + 2000) * 10);
		$display("watchdog ended the run after %0d cycles", 20 * frame_cycles + 2000);
		stop_run();
	end

	initial
	begin
		addr_t addr;
		byte_t data;
		addr_t host_addrs [8];
		clk = 1'b0;
		btnC <= 1'b1;
		cpu_a <= '0;
		cpu_dout <= '0;
		cpu_wr <= 1'b0;
		host_active <= 1'b0;
		host_a <= '0;
		host_dout <= '0;
		host_wr <= 1'b0;
		repeat (2) @(posedge clk);
		btnC <= 1'b0;
		@(negedge clk);
		check_value("cpu_rst", 1, cpu_rst);
		wait_reset_release();
		check_value("tx", 1, tx);
		check_value("finish", 0, finish);
		check_value("led", 0, led);
		check_value("cpu_rdy", 1, cpu_rdy);

		// random core traffic over RAM
		for (int i = 0; i < n_random; i++)
		begin
			addr = addr_t'($random(seed)) & ram_mask;
			data = byte_t'($random(seed));
			core_write(addr, data);
			if (!shadow.exists(addr))
				written_q.push_back(addr);
			shadow[addr] = data;
		end
		foreach (written_q[i])
		begin
			core_read(written_q[i], data);
			check_value("cpu_din", shadow[written_q[i]], data);
		end

		// debug break
		@(posedge clk);
		host_active <= 1'b1;
		@(negedge clk);
		check_value("cpu_rdy", 0, cpu_rdy);
		check_value("led", 1, led);
		for (int i = 0; i < 8; i++)
		begin
			host_read(written_q[i], data);
			check_value("host_din", shadow[written_q[i]], data);
		end
		for (int i = 0; i < 8; i++)
		begin
			host_addrs[i] = addr_t'($random(seed)) & ram_mask;
			data = byte_t'($random(seed));
			host_write(host_addrs[i], data);
			shadow[host_addrs[i]] = data;
		end
		@(posedge clk);
		host_active <= 1'b0;
		@(negedge clk);
		check_value("cpu_rdy", 1, cpu_rdy);
		for (int i = 0; i < 8; i++)
		begin
			core_read(host_addrs[i], data);
			check_value("cpu_din", shadow[host_addrs[i]], data);
		end

		// character output
		for (int i = 0; i < 4; i++)
		begin
			data = byte_t'($random(seed));
			core_write(io_base + IO_SEL_CHAR, data);
			exp_q.push_back(data);
		end
		wait_frames(4);
		wait_tx_idle();

		// idle transmitter takes the first byte, FIFO_DEPTH more fill the queue
		for (int i = 0; i < FIFO_DEPTH + 2; i++)
		begin
			data = byte_t'($random(seed));
			core_write(io_base + IO_SEL_CHAR, data);
			if (i <= FIFO_DEPTH)
				exp_q.push_back(data);
		end
		core_read(io_base + IO_SEL_STATUS, data);
		check_value("status", 8'h03, data);
		wait_frames(FIFO_DEPTH + 1);
		repeat (2 * frame_cycles) @(negedge clk);
		check_value("extra tx frames", 0, rx_q.size());

		// program finish
		check_value("finish", 0, finish);
		data = byte_t'($random(seed));
		core_write(io_base + IO_SEL_FINISH, data);
		@(negedge clk);
		check_value("finish", 1, finish);
		check_value("exit_code", data, exit_code);
		repeat (20)
		begin
			check_value("cpu_rst", 1, cpu_rst);
			@(negedge clk);
		end

		if (uut.u_props.failures == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
			stop_run();
	end

endmodule

// ==== sim.f ====
verilog/soc_pkg.sv
verilog/reset_sync.sv
verilog/bus_master_mux.sv
verilog/mem_decode.sv
verilog/ram.sv
verilog/io_ctrl.sv
verilog/uart_tx.sv
verilog/soc_top.sv
tests/soc_properties.sv
tests/soc_tb.sv

// ==== Makefile ====
TOP = soc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert --top-module $(TOP) -f sim.f

# pass only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
